// File: hal_top.f
design/hal_pkg.sv
design/sync_polarity.sv
design/vga_sync_out.sv
design/host_cmd_decoder.sv
design/button_debouncer.sv
design/led_ctrl.sv
design/audio_mixer.sv
design/hal_top.sv
verif/hal_assertions.sv
verif/hal_tb.sv

// File: verif/hal_tb.sv
module hal_tb;

	localparam int ACK_TIMEOUT = 20;
	localparam int BTN_TIMEOUT = 12 * (hal_pkg::DEBOUNCE_DIV + 1);

	logic               FPGA_CLK2_50;
	logic               resetd;
	hal_pkg::io_word_t  io_din;
	logic               io_clk, io_uio, io_ack;
	hal_pkg::io_word_t  cfg;
	hal_pkg::timing_t   width, h_fp, h_sync, h_bp, height, v_fp, v_sync, v_bp;
	logic               btn_user_n, btn_osd_n, btn_user, btn_osd;
	logic [1:0]         key;
	logic               core_led_user, core_led_disk;
	logic [1:0]         core_led_power;
	logic               led_power_on, led_hdd_on, led_user_on;
	hal_pkg::led_byte_t led;
	hal_pkg::audio_t    audio_in_l, audio_in_r, audio_l, audio_r;
	logic               audio_signed;
	hal_pkg::mix_t      audio_mix;
	logic               core_hs, core_vs, vga_hs, vga_vs;

	// Expected state of the host registers
	string              cur_test;
	hal_pkg::io_word_t  frame_data[$];
	hal_pkg::timing_t   exp_timing[8];
	hal_pkg::io_word_t  exp_cfg;
	hal_pkg::io_word_t  exp_ovr;

	hal_top i_dut (.*);

	initial FPGA_CLK2_50 = 1'b0;
	always #5 FPGA_CLK2_50 = ~FPGA_CLK2_50;

	// ================================================
	// Compare tasks
	// ================================================
	task automatic fail_stop(input string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input string what, input hal_pkg::io_word_t exp,
			input hal_pkg::io_word_t act);
		if (act !== exp)
			fail_stop($sformatf("FAIL %s %s: expected %h, actual %h", cur_test, what, exp, act));
	endtask

	task automatic check_timing(input string what, input hal_pkg::timing_t exp,
			input hal_pkg::timing_t act);
		if (act !== exp)
			fail_stop($sformatf("FAIL %s %s: expected %0d, actual %0d", cur_test, what, exp, act));
	endtask

	task automatic check_led(input string what, input hal_pkg::led_byte_t exp,
			input hal_pkg::led_byte_t act);
		if (act !== exp)
			fail_stop($sformatf("FAIL %s %s: expected %b, actual %b", cur_test, what, exp, act));
	endtask

	task automatic check_audio(input string what, input hal_pkg::audio_t exp,
			input hal_pkg::audio_t act);
		if (act !== exp)
			fail_stop($sformatf("FAIL %s %s: expected %h, actual %h", cur_test, what, exp, act));
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		if (act !== exp)
			fail_stop($sformatf("FAIL %s %s: expected %b, actual %b", cur_test, what, exp, act));
	endtask

	task automatic check_timings();
		check_timing("width", exp_timing[0], width);
		check_timing("h_fp", exp_timing[1], h_fp);
		check_timing("h_sync", exp_timing[2], h_sync);
		check_timing("h_bp", exp_timing[3], h_bp);
		check_timing("height", exp_timing[4], height);
		check_timing("v_fp", exp_timing[5], v_fp);
		check_timing("v_sync", exp_timing[6], v_sync);
		check_timing("v_bp", exp_timing[7], v_bp);
	endtask

	// Default byte: power lamp bit 4, disk bit 2, user bit 0
	function automatic hal_pkg::led_byte_t led_expect(input hal_pkg::io_word_t ovr);
		hal_pkg::led_byte_t def;
		hal_pkg::led_byte_t res;
		def = '0;
		def[4] = !core_led_power[1] || (core_led_power == 2'b11);
		def[2] = core_led_disk;
		def[0] = core_led_user;
		for (int i = 0; i < 8; i++)
			res[i] = ovr[8 + i] ? ovr[i] : def[i];
		return res;
	endfunction

	function automatic hal_pkg::audio_t mix_expect(input hal_pkg::audio_t own,
			input hal_pkg::audio_t other, input logic sgn, input hal_pkg::mix_t mode);
		int a;
		int b;
		int r;
		if (sgn) begin
			a = $signed(own);
			b = $signed(other);
		end else begin
			a = own;
			b = other;
		end
		case (mode)
			hal_pkg::MIX_EIGHTH:  r = a - (a >>> 3) + (b >>> 3);
			hal_pkg::MIX_QUARTER: r = a - (a >>> 2) + (b >>> 2);
			hal_pkg::MIX_HALF:    r = (a >>> 1) + (b >>> 1);
			default:              r = a;
		endcase
		return r[15:0];
	endfunction

	// ================================================
	// Host handshake
	// ================================================
	task automatic wait_ack(input logic level);
		int n;
		n = 0;
		while (io_ack !== level) begin
			if (n == ACK_TIMEOUT)
				fail_stop($sformatf("Timeout: io_ack did not go to %0b", level));
			@(negedge FPGA_CLK2_50);
			n++;
		end
	endtask

	task automatic send_word(input hal_pkg::io_word_t w);
		io_din = w;
		@(negedge FPGA_CLK2_50);
		io_clk = 1'b1;
		@(negedge FPGA_CLK2_50);
		wait_ack(1'b1);
		io_clk = 1'b0;
		@(negedge FPGA_CLK2_50);
		wait_ack(1'b0);
	endtask

	// Command code, then every word queued in frame_data
	task automatic send_frame(input hal_pkg::cmd_t code);
		io_uio = 1'b1;
		send_word({8'h00, code});
		foreach (frame_data[i])
			send_word(frame_data[i]);
		io_uio = 1'b0;
		repeat (4) @(negedge FPGA_CLK2_50);
	endtask

	task automatic fill_random(input int n);
		frame_data.delete();
		repeat (n)
			frame_data.push_back(hal_pkg::io_word_t'($urandom));
	endtask

	task automatic wait_button(input bit user, input logic level);
		int n;
		n = 0;
		while ((user ? btn_user : btn_osd) !== level) begin
			if (n == BTN_TIMEOUT)
				fail_stop($sformatf("Timeout: %s button never went to %0b",
					user ? "user" : "OSD", level));
			@(negedge FPGA_CLK2_50);
			n++;
		end
	endtask

	// ================================================
	// Directed tests
	// ================================================
	task automatic reset_values();
		cur_test = "reset_values";
		check_bit("io_ack", 1'b0, io_ack);
		check_word("cfg", '0, cfg);
		check_timings();
		check_led("led", led_expect('0), led);
		check_bit("btn_user", 1'b0, btn_user);
		check_bit("btn_osd", 1'b0, btn_osd);
		check_audio("audio_l", '0, audio_l);
		check_audio("audio_r", '0, audio_r);
	endtask

	task automatic cfg_command();
		cur_test = "cfg_command";
		fill_random(1);
		exp_cfg = frame_data[0];
		send_frame(hal_pkg::CMD_CFG);
		check_word("cfg", exp_cfg, cfg);
	endtask

	task automatic timing_command();
		cur_test = "timing_command";
		// Ninth word must be dropped
		fill_random(9);
		for (int i = 0; i < 8; i++)
			exp_timing[i] = frame_data[i][11:0];
		send_frame(hal_pkg::CMD_TIMING);
		check_timings();
	endtask

	task automatic led_command();
		cur_test = "led_command";
		fill_random(1);
		exp_ovr = frame_data[0];
		send_frame(hal_pkg::CMD_LED);
		for (int p = 0; p < 4; p++) begin
			for (int d = 0; d < 2; d++) begin
				core_led_power = p[1:0];
				core_led_disk = d[0];
				core_led_user = 1'($urandom);
				@(negedge FPGA_CLK2_50);
				check_led("led", led_expect(exp_ovr), led);
				check_bit("led_hdd_on", d[0], led_hdd_on);
				check_bit("led_power_on", (p < 2) || (p == 3), led_power_on);
				check_bit("led_user_on", core_led_user, led_user_on);
			end
		end
	endtask

	task automatic unknown_command();
		cur_test = "unknown_command";
		fill_random(9);
		send_frame(8'h33);
		check_word("cfg", exp_cfg, cfg);
		check_timings();
		check_led("led", led_expect(exp_ovr), led);
	endtask

	task automatic button_press();
		cur_test = "button_press";
		btn_user_n = 1'b0;
		wait_button(1'b1, 1'b1);
		btn_user_n = 1'b1;
		wait_button(1'b1, 1'b0);
		key[0] = 1'b0;
		wait_button(1'b0, 1'b1);
		check_bit("btn_user", 1'b0, btn_user);
		key[0] = 1'b1;
	endtask

	task automatic button_glitch();
		cur_test = "button_glitch";
		// OSD release lands on a sample edge so the pulse below spans the next one
		wait_button(1'b0, 1'b0);
		repeat (hal_pkg::DEBOUNCE_DIV - 50) @(negedge FPGA_CLK2_50);
		btn_user_n = 1'b0;
		repeat (100) @(negedge FPGA_CLK2_50);
		btn_user_n = 1'b1;
		repeat (3 * (hal_pkg::DEBOUNCE_DIV + 1)) begin
			@(negedge FPGA_CLK2_50);
			check_bit("btn_user", 1'b0, btn_user);
		end
	endtask

	task automatic audio_mix_all();
		hal_pkg::audio_t l;
		hal_pkg::audio_t r;
		cur_test = "audio_mix_all";
		for (int s = 0; s < 2; s++) begin
			for (int m = 0; m < 4; m++) begin
				repeat (4) begin
					l = hal_pkg::audio_t'($urandom);
					r = hal_pkg::audio_t'($urandom);
					audio_in_l = l;
					audio_in_r = r;
					audio_signed = s[0];
					audio_mix = hal_pkg::mix_t'(m);
					@(negedge FPGA_CLK2_50);
					check_audio("audio_l", mix_expect(l, r, s[0], audio_mix), audio_l);
					check_audio("audio_r", mix_expect(r, l, s[0], audio_mix), audio_r);
				end
			end
		end
	endtask

	// hs is long high, vs long low; only the last two periods are checked
	task automatic run_sync(input logic cs);
		logic hn;
		logic vn;
		for (int p = 0; p < 5; p++) begin
			for (int c = 0; c < 60; c++) begin
				if (p >= 3) begin
					hn = ~core_hs;
					vn = core_vs;
					check_bit("vga_hs", cs ? ~(hn ^ vn) : ~hn, vga_hs);
					check_bit("vga_vs", cs ? 1'b1 : ~vn, vga_vs);
				end
				core_hs = (c < 45);
				core_vs = (c < 12);
				@(negedge FPGA_CLK2_50);
			end
		end
	endtask

	task automatic sync_outputs();
		cur_test = "sync_outputs";
		frame_data = {16'h0000};
		send_frame(hal_pkg::CMD_CFG);
		run_sync(1'b0);
		frame_data = {16'h0008};
		send_frame(hal_pkg::CMD_CFG);
		run_sync(1'b1);
	endtask

	initial begin
		void'($urandom(32'h8c64c592));
		resetd = 1'b1;
		io_din = '0;
		io_clk = 1'b0;
		io_uio = 1'b0;
		btn_user_n = 1'b1;
		btn_osd_n = 1'b1;
		key = 2'b11;
		core_led_user = 1'b0;
		core_led_power = 2'b00;
		core_led_disk = 1'b0;
		audio_in_l = '0;
		audio_in_r = '0;
		audio_signed = 1'b0;
		audio_mix = hal_pkg::MIX_NONE;
		core_hs = 1'b0;
		core_vs = 1'b0;
		exp_timing = '{12'd1280, 12'd110, 12'd40, 12'd220, 12'd720, 12'd5, 12'd5, 12'd20};
		exp_cfg = '0;
		exp_ovr = '0;
		repeat (5) @(negedge FPGA_CLK2_50);
		resetd = 1'b0;
		@(negedge FPGA_CLK2_50);

		reset_values();
		cfg_command();
		timing_command();
		led_command();
		unknown_command();
		audio_mix_all();
		sync_outputs();
		button_press();
		button_glitch();

		if (i_dut.i_hal_assertions.fail_cnt != 0) begin
			fail_stop("Concurrent assertions reported failures");
		end else begin
			$display("TB PASSED");
			$finish;
		end
	end

endmodule

// File: verif/hal_assertions.sv
module hal_assertions (
	input logic            FPGA_CLK2_50,
	input logic            resetd,
	input logic            io_clk,
	input logic            io_ack,
	input hal_pkg::audio_t audio_l,
	input hal_pkg::audio_t audio_r
);

	int fail_cnt = 0;

	// Acknowledge is cleared by the synchronous reset
	ack_in_reset: assert property (@(posedge FPGA_CLK2_50) resetd |=> !io_ack)
		else begin
			fail_cnt++;
			$error("io_ack high while resetd is high");
		end

	// Two synchroniser stages sit between io_clk and io_ack
	ack_after_clk: assert property (@(posedge FPGA_CLK2_50) disable iff (resetd)
		$rose(io_ack) |-> $past(io_clk, 1) && $past(io_clk, 2))
		else begin
			fail_cnt++;
			$error("io_ack rose without io_clk high for two cycles");
		end

	audio_known: assert property (@(posedge FPGA_CLK2_50) disable iff (resetd)
		!$isunknown({audio_l, audio_r}))
		else begin
			fail_cnt++;
			$error("audio output unknown outside reset");
		end

endmodule

bind hal_top hal_assertions i_hal_assertions (
	.FPGA_CLK2_50(FPGA_CLK2_50),
	.resetd(resetd),
	.io_clk(io_clk),
	.io_ack(io_ack),
	.audio_l(audio_l),
	.audio_r(audio_r)
);

// File: design/hal_top.sv
module hal_top (
	input  logic              FPGA_CLK2_50,
	input  logic              resetd,

	// Host word port
	input  hal_pkg::io_word_t io_din,
	input  logic              io_clk,
	input  logic              io_uio,
	output logic              io_ack,
	output hal_pkg::io_word_t cfg,

	// Video timing
	output hal_pkg::timing_t  width,
	output hal_pkg::timing_t  h_fp,
	output hal_pkg::timing_t  h_sync,
	output hal_pkg::timing_t  h_bp,
	output hal_pkg::timing_t  height,
	output hal_pkg::timing_t  v_fp,
	output hal_pkg::timing_t  v_sync,
	output hal_pkg::timing_t  v_bp,

	// Buttons
	input  logic              btn_user_n,
	input  logic              btn_osd_n,
	input  logic [1:0]        key,
	output logic              btn_user,
	output logic              btn_osd,

	// LEDs
	input  logic              core_led_user,
	input  logic [1:0]        core_led_power,
	input  logic              core_led_disk,
	output logic              led_power_on,
	output logic              led_hdd_on,
	output logic              led_user_on,
	output hal_pkg::led_byte_t led,

	// Audio
	input  hal_pkg::audio_t   audio_in_l,
	input  hal_pkg::audio_t   audio_in_r,
	input  logic              audio_signed,
	input  hal_pkg::mix_t     audio_mix,
	output hal_pkg::audio_t   audio_l,
	output hal_pkg::audio_t   audio_r,

	// VGA sync
	input  logic              core_hs,
	input  logic              core_vs,
	output logic              vga_hs,
	output logic              vga_vs
);

	logic              led_wr;
	hal_pkg::io_word_t led_word;
	logic              csync;

	host_cmd_decoder i_host_cmd_decoder (
		.FPGA_CLK2_50(FPGA_CLK2_50), .resetd(resetd),
		.io_din(io_din), .io_clk(io_clk), .io_uio(io_uio),
		.io_ack(io_ack), .cfg(cfg), .csync(csync),
		.width(width), .h_fp(h_fp), .h_sync(h_sync), .h_bp(h_bp),
		.height(height), .v_fp(v_fp), .v_sync(v_sync), .v_bp(v_bp),
		.led_wr(led_wr), .led_word(led_word)
	);

	button_debouncer i_button_debouncer (
		.FPGA_CLK2_50(FPGA_CLK2_50), .resetd(resetd),
		.btn_user_n(btn_user_n), .btn_osd_n(btn_osd_n), .key(key),
		.btn_user(btn_user), .btn_osd(btn_osd)
	);

	led_ctrl i_led_ctrl (
		.FPGA_CLK2_50(FPGA_CLK2_50), .resetd(resetd),
		.led_wr(led_wr), .led_word(led_word),
		.core_led_user(core_led_user), .core_led_power(core_led_power),
		.core_led_disk(core_led_disk),
		.led_power_on(led_power_on), .led_hdd_on(led_hdd_on),
		.led_user_on(led_user_on), .led(led)
	);

	audio_mixer i_audio_mixer (
		.FPGA_CLK2_50(FPGA_CLK2_50), .resetd(resetd),
		.audio_in_l(audio_in_l), .audio_in_r(audio_in_r),
		.audio_signed(audio_signed), .audio_mix(audio_mix),
		.audio_l(audio_l), .audio_r(audio_r)
	);

	vga_sync_out i_vga_sync_out (
		.FPGA_CLK2_50(FPGA_CLK2_50), .resetd(resetd),
		.core_hs(core_hs), .core_vs(core_vs), .csync(csync),
		.vga_hs(vga_hs), .vga_vs(vga_vs)
	);

endmodule

// File: design/audio_mixer.sv
module audio_mixer (
	input  logic            FPGA_CLK2_50,
	input  logic            resetd,
	input  hal_pkg::audio_t audio_in_l,
	input  hal_pkg::audio_t audio_in_r,
	input  logic            audio_signed,
	input  hal_pkg::mix_t   audio_mix,
	output hal_pkg::audio_t audio_l,
	output hal_pkg::audio_t audio_r
);

	// Arithmetic shift for signed samples, logical for unsigned
	function automatic hal_pkg::audio_t shr(
		input hal_pkg::audio_t x,
		input int unsigned     k,
		input logic            arith
	);
		if (arith) begin
			return hal_pkg::audio_t'($signed(x) >>> k);
		end else begin
			return x >> k;
		end
	endfunction

	// One output channel, wraps to 16 bits
	function automatic hal_pkg::audio_t mix_chan(
		input hal_pkg::audio_t own,
		input hal_pkg::audio_t other,
		input hal_pkg::mix_t   mode,
		input logic            arith
	);
		case (mode)
			hal_pkg::MIX_EIGHTH:  return own - shr(own, 3, arith) + shr(other, 3, arith);
			hal_pkg::MIX_QUARTER: return own - shr(own, 2, arith) + shr(other, 2, arith);
			hal_pkg::MIX_HALF:    return shr(own, 1, arith) + shr(other, 1, arith);
			default:              return own;
		endcase
	endfunction

	hal_pkg::audio_t mix_l, mix_r;

	assign mix_l = mix_chan(audio_in_l, audio_in_r, audio_mix, audio_signed);
	assign mix_r = mix_chan(audio_in_r, audio_in_l, audio_mix, audio_signed);

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			audio_l <= '0;
			audio_r <= '0;
		end else begin
			audio_l <= mix_l;
			audio_r <= mix_r;
		end
	end

endmodule

// File: design/led_ctrl.sv
module led_ctrl (
	input  logic               FPGA_CLK2_50,
	input  logic               resetd,
	input  logic               led_wr,
	input  hal_pkg::io_word_t  led_word,
	input  logic               core_led_user,
	input  logic [1:0]         core_led_power,
	input  logic               core_led_disk,
	output logic               led_power_on,
	output logic               led_hdd_on,
	output logic               led_user_on,
	output hal_pkg::led_byte_t led
);

	hal_pkg::led_byte_t led_overtake;
	hal_pkg::led_byte_t led_state;
	hal_pkg::led_byte_t led_default;
	logic               power_on;

	// Bit 1 low means always on, otherwise bit 0 decides
	assign power_on    = ~core_led_power[1] | core_led_power[0];
	assign led_default = {3'b000, power_on, 1'b0, core_led_disk, 1'b0, core_led_user};

	// Host override, mask in the high byte
	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			led_overtake <= '0;
			led_state    <= '0;
		end else if (led_wr) begin
			{led_overtake, led_state} <= led_word;
		end
	end

	always_ff @(posedge FPGA_CLK2_50) begin
		led_power_on <= power_on;
		led_hdd_on   <= core_led_disk;
		led_user_on  <= core_led_user;
		led          <= (led_overtake & led_state) | (~led_overtake & led_default);
	end

endmodule

// File: design/button_debouncer.sv
module button_debouncer (
	input  logic       FPGA_CLK2_50,
	input  logic       resetd,
	input  logic       btn_user_n,
	input  logic       btn_osd_n,
	input  logic [1:0] key,
	output logic       btn_user,
	output logic       btn_osd
);

	logic [hal_pkg::DEBOUNCE_DIV_W-1:0]            div_cnt;
	logic [1:0]                                    pressed;
	logic [1:0][hal_pkg::DEBOUNCE_DEPTH-1:0]       hist;
	logic [1:0][hal_pkg::DEBOUNCE_DEPTH-1:0]       hist_next;
	logic [1:0]                                    state;

	// Index 1 is the user button, index 0 the OSD button
	assign pressed = {~(btn_user_n & key[1]), ~(btn_osd_n & key[0])};

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			hist_next[i] = {hist[i][hal_pkg::DEBOUNCE_DEPTH-2:0], pressed[i]};
		end
	end

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			div_cnt <= '0;
			hist    <= '0;
			state   <= '0;
		end else begin
			div_cnt <= (div_cnt == hal_pkg::DEBOUNCE_DIV) ? '0 : div_cnt + 1'b1;
			if (div_cnt == '0) begin
				hist <= hist_next;
				for (int i = 0; i < 2; i++) begin
					if (&hist_next[i]) state[i] <= 1'b1;
					if (~|hist_next[i]) state[i] <= 1'b0;
				end
			end
		end
	end

	assign btn_user = state[1];
	assign btn_osd  = state[0];

endmodule

// File: design/host_cmd_decoder.sv
module host_cmd_decoder (
	input  logic              FPGA_CLK2_50,
	input  logic              resetd,
	input  hal_pkg::io_word_t io_din,
	input  logic              io_clk,
	input  logic              io_uio,
	output logic              io_ack,
	output hal_pkg::io_word_t cfg,
	output logic              csync,
	output hal_pkg::timing_t  width,
	output hal_pkg::timing_t  h_fp,
	output hal_pkg::timing_t  h_sync,
	output hal_pkg::timing_t  h_bp,
	output hal_pkg::timing_t  height,
	output hal_pkg::timing_t  v_fp,
	output hal_pkg::timing_t  v_sync,
	output hal_pkg::timing_t  v_bp,
	output logic              led_wr,
	output hal_pkg::io_word_t led_word
);

	// ================================================
	// Host input synchroniser
	// ================================================
	logic              io_clk_s1, io_clk_s2;
	logic              io_uio_s1, io_uio_s2;
	hal_pkg::io_word_t io_din_s1, io_din_s2;
	logic              io_strobe;

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			io_clk_s1 <= 1'b0;
			io_clk_s2 <= 1'b0;
			io_uio_s1 <= 1'b0;
			io_uio_s2 <= 1'b0;
		end else begin
			io_clk_s1 <= io_clk;
			io_clk_s2 <= io_clk_s1;
			io_uio_s1 <= io_uio;
			io_uio_s2 <= io_uio_s1;
		end
	end

	always_ff @(posedge FPGA_CLK2_50) begin
		io_din_s1 <= io_din;
		io_din_s2 <= io_din_s1;
	end

	// io_ack doubles as the delayed clock, so a held io_clk gives one strobe only
	assign io_strobe = io_clk_s2 & ~io_ack;

	// ================================================
	// Command parser
	// ================================================
	logic                             has_cmd;
	hal_pkg::cmd_t                    cmd;
	logic [hal_pkg::TIMING_CNT_W-1:0] cnt;
	hal_pkg::timing_t                 din_timing;

	assign din_timing = io_din_s2[hal_pkg::TIMING_W-1:0];

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			io_ack  <= 1'b0;
			has_cmd <= 1'b0;
			cmd     <= '0;
			cnt     <= '0;
			led_wr  <= 1'b0;
			cfg     <= '0;
			width   <= hal_pkg::DEF_WIDTH;
			h_fp    <= hal_pkg::DEF_HFP;
			h_sync  <= hal_pkg::DEF_HS;
			h_bp    <= hal_pkg::DEF_HBP;
			height  <= hal_pkg::DEF_HEIGHT;
			v_fp    <= hal_pkg::DEF_VFP;
			v_sync  <= hal_pkg::DEF_VS;
			v_bp    <= hal_pkg::DEF_VBP;
		end else begin
			io_ack <= io_clk_s2;
			led_wr <= 1'b0;
			if (!io_uio_s2) begin
				has_cmd <= 1'b0;
			end else if (io_strobe) begin
				if (!has_cmd) begin
					// First word of the frame is the command code
					has_cmd <= 1'b1;
					cmd     <= io_din_s2[hal_pkg::CMD_W-1:0];
					cnt     <= '0;
				end else begin
					case (cmd)
						hal_pkg::CMD_CFG: cfg <= io_din_s2;
						hal_pkg::CMD_LED: led_wr <= 1'b1;
						hal_pkg::CMD_TIMING: begin
							if (cnt < hal_pkg::TIMING_WORDS) begin
								cnt <= cnt + 1'b1;
								case (cnt)
									4'd0: width  <= din_timing;
									4'd1: h_fp   <= din_timing;
									4'd2: h_sync <= din_timing;
									4'd3: h_bp   <= din_timing;
									4'd4: height <= din_timing;
									4'd5: v_fp   <= din_timing;
									4'd6: v_sync <= din_timing;
									default: v_bp <= din_timing;
								endcase
							end
						end
						default: begin
						end
					endcase
				end
			end
		end
	end

	// LED word is only looked at together with led_wr
	always_ff @(posedge FPGA_CLK2_50) begin
		if (io_strobe) begin
			led_word <= io_din_s2;
		end
	end

	assign csync = cfg[hal_pkg::CFG_CSYNC_BIT];

endmodule

// File: design/vga_sync_out.sv
module vga_sync_out (
	input  logic FPGA_CLK2_50,
	input  logic resetd,
	input  logic core_hs,
	input  logic core_vs,
	input  logic csync,
	output logic vga_hs,
	output logic vga_vs
);

	logic hs_norm, vs_norm;

	sync_polarity i_sync_h (
		.FPGA_CLK2_50(FPGA_CLK2_50),
		.resetd(resetd),
		.sync_in(core_hs),
		.sync_out(hs_norm)
	);

	sync_polarity i_sync_v (
		.FPGA_CLK2_50(FPGA_CLK2_50),
		.resetd(resetd),
		.sync_in(core_vs),
		.sync_out(vs_norm)
	);

	// VGA wants active-low syncs
	// composite sync rides on hs with vs parked high
	assign vga_hs = csync ? ~(hs_norm ^ vs_norm) : ~hs_norm;
	assign vga_vs = csync ? 1'b1 : ~vs_norm;

endmodule

// File: design/sync_polarity.sv
module sync_polarity (
	input  logic FPGA_CLK2_50,
	input  logic resetd,
	input  logic sync_in,
	output logic sync_out
);

	logic                           s1, s2;
	logic [hal_pkg::SYNC_CNT_W-1:0] cnt;
	logic [hal_pkg::SYNC_CNT_W-1:0] hi_len;
	logic [hal_pkg::SYNC_CNT_W-1:0] lo_len;
	logic                           pol;

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			s1     <= 1'b0;
			s2     <= 1'b0;
			cnt    <= '0;
			hi_len <= '0;
			lo_len <= '0;
			pol    <= 1'b0;
		end else begin
			s1 <= sync_in;
			s2 <= s1;
			if (s1 != s2) begin
				cnt <= '0;
				// Rising edge closes a low phase, falling edge a high one
				if (s1) begin
					lo_len <= cnt;
				end else begin
					hi_len <= cnt;
				end
			end else if (cnt != '1) begin
				cnt <= cnt + 1'b1;
			end
			pol <= hi_len > lo_len;
		end
	end

	// Shorter phase always comes out as the high pulse
	assign sync_out = sync_in ^ pol;

endmodule

// File: design/hal_pkg.sv
package hal_pkg;

	// ================================================
	// Widths
	// ================================================
	localparam int IO_WORD_W    = 16;
	localparam int TIMING_W     = 12;
	localparam int CMD_W        = 8;
	localparam int LED_W        = 8;
	localparam int AUDIO_W      = 16;
	localparam int TIMING_WORDS = 8;
	localparam int TIMING_CNT_W = $clog2(TIMING_WORDS + 1);

	// Host command codes
	localparam logic [CMD_W-1:0] CMD_CFG    = 8'h01;
	localparam logic [CMD_W-1:0] CMD_TIMING = 8'h20;
	localparam logic [CMD_W-1:0] CMD_LED    = 8'h25;

	// Composite sync enable inside cfg
	localparam int CFG_CSYNC_BIT = 3;

	// Button sampling, one tick every DEBOUNCE_DIV + 1 cycles
	localparam int DEBOUNCE_DIV   = 100000;
	localparam int DEBOUNCE_DIV_W = $clog2(DEBOUNCE_DIV + 1);
	localparam int DEBOUNCE_DEPTH = 8;

	// Enough for one full frame at 50 MHz
	localparam int SYNC_CNT_W = 20;

	typedef logic [IO_WORD_W-1:0] io_word_t;
	typedef logic [CMD_W-1:0]     cmd_t;
	typedef logic [TIMING_W-1:0]  timing_t;
	typedef logic [LED_W-1:0]     led_byte_t;
	typedef logic [AUDIO_W-1:0]   audio_t;

	typedef enum logic [1:0] {
		MIX_NONE,
		MIX_EIGHTH,
		MIX_QUARTER,
		MIX_HALF
	} mix_t;

	// 1280x720@60 until the host says otherwise
	localparam timing_t DEF_WIDTH  = 12'd1280;
	localparam timing_t DEF_HFP    = 12'd110;
	localparam timing_t DEF_HS     = 12'd40;
	localparam timing_t DEF_HBP    = 12'd220;
	localparam timing_t DEF_HEIGHT = 12'd720;
	localparam timing_t DEF_VFP    = 12'd5;
	localparam timing_t DEF_VS     = 12'd5;
	localparam timing_t DEF_VBP    = 12'd20;

endpackage
